//--- list.f
+incdir+test
hdl/ex_pkg.sv
hdl/operand_select.sv
hdl/alu_bit.sv
hdl/alu_flags.sv
hdl/branch_unit.sv
hdl/execute_stage.sv
test/execute_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
	-f list.f \
	--top-module execute_stage_tb \
	-o execute_stage_tb

# the log decides pass or fail, not the exit status
./obj_dir/execute_stage_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST OK" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

//--- test/ex_vectors.svh
// directed stimulus for the execute stage testbench
// each row is one request plus the alu_result worked out by hand
// columns: read_data1, read_data2 / pc, imm_ext, br_offset /
//          alu_op, alu_src, set_flags, br_kind, expected alu_result
`ifndef EX_VECTORS_SVH
`define EX_VECTORS_SVH

typedef struct packed {
	ex_req_t           req;
	logic [DATA_W-1:0] exp_result;
} row_t;

localparam int N_DIR = 20;

localparam row_t DIRECTED [N_DIR] = '{
	// plain add, flags all clear
	'{'{64'h5, 64'h7,
	    64'h1000, 64'h0, 64'h4,
	    ALU_ADD, 1'b0, 1'b1, BR_NONE}, 64'hc},
	// add with immediate, unconditional branch
	'{'{64'h10, 64'hdead,
	    64'h1004, 64'h20, 64'h1,
	    ALU_ADD, 1'b1, 1'b0, BR_ALWAYS}, 64'h30},
	// equal compare gives zero and carry
	'{'{64'h7, 64'h7,
	    64'h1008, 64'h0, 64'h8,
	    ALU_SUB, 1'b0, 1'b1, BR_NONE}, 64'h0},
	// positive add overflow at the top boundary
	'{'{64'h7fff_ffff_ffff_ffff, 64'h1,
	    64'h100c, 64'h0, 64'h0,
	    ALU_ADD, 1'b0, 1'b1, BR_NONE}, 64'h8000_0000_0000_0000},
	// n and v both set, lt not taken
	'{'{64'h0, 64'h1234,
	    64'h1010, 64'h0, 64'h10,
	    ALU_PASS_B, 1'b0, 1'b0, BR_LT}, 64'h1234},
	// subtract overflow at the bottom boundary
	'{'{64'h8000_0000_0000_0000, 64'h1,
	    64'h1014, 64'h0, 64'h3,
	    ALU_SUB, 1'b0, 1'b1, BR_NONE}, 64'h7fff_ffff_ffff_ffff},
	// v without n, lt taken backwards
	'{'{64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0,
	    64'h2000, 64'h0, 64'hffff_ffff_ffff_fffe,
	    ALU_AND, 1'b0, 1'b0, BR_LT}, 64'h0f00_0f00_0f00_0f00},
	// unsigned wrap, zero and carry
	'{'{64'hffff_ffff_ffff_ffff, 64'h1,
	    64'h2004, 64'h0, 64'h0,
	    ALU_ADD, 1'b0, 1'b1, BR_NONE}, 64'h0},
	// logic op clears v and c
	'{'{64'hf0f0, 64'h9,
	    64'h2008, 64'h0f0f, 64'h2,
	    ALU_OR, 1'b1, 1'b1, BR_NONE}, 64'hffff},
	// cbz on a nonzero register
	'{'{64'haaaa_aaaa_aaaa_aaaa, 64'h5555_5555_5555_5555,
	    64'h200c, 64'h0, 64'h5,
	    ALU_XOR, 1'b0, 1'b1, BR_CBZ}, 64'hffff_ffff_ffff_ffff},
	// cbz on zero
	'{'{64'h77, 64'h0,
	    64'h2010, 64'h99, 64'h6,
	    ALU_PASS_B, 1'b0, 1'b0, BR_CBZ}, 64'h0},
	// pass the immediate
	'{'{64'h1, 64'h2,
	    64'h2014, 64'h0123_4567_89ab_cdef, 64'h7,
	    ALU_PASS_B, 1'b1, 1'b0, BR_NONE}, 64'h0123_4567_89ab_cdef},
	// 3 < 5 compare, negative with borrow
	'{'{64'h3, 64'h5,
	    64'h3000, 64'h0, 64'h1,
	    ALU_SUB, 1'b0, 1'b1, BR_NONE}, 64'hffff_ffff_ffff_fffe},
	// unused op code, lt taken after the compare
	'{'{64'h55, 64'h66,
	    64'h3004, 64'h0, 64'hffff_ffff_ffff_fff0,
	    3'b001, 1'b0, 1'b0, BR_LT}, 64'h0},
	// unused op code sets zero
	'{'{64'h55, 64'h66,
	    64'h3008, 64'h1, 64'h0,
	    3'b111, 1'b0, 1'b1, BR_NONE}, 64'h0},
	// subtract immediate, carry only
	'{'{64'h100, 64'h3,
	    64'h300c, 64'h1, 64'h9,
	    ALU_SUB, 1'b1, 1'b1, BR_NONE}, 64'hff},
	// xor immediate, lt not taken
	'{'{64'h1, 64'h8,
	    64'h3010, 64'h1, 64'ha,
	    ALU_XOR, 1'b1, 1'b0, BR_LT}, 64'h0},
	// add without set_flags
	'{'{64'h1, 64'h2,
	    64'h3014, 64'h0, 64'hb,
	    ALU_ADD, 1'b0, 1'b0, BR_ALWAYS}, 64'h3},
	// max positive minus minus one overflows
	'{'{64'h7fff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff,
	    64'h3018, 64'h0, 64'hc,
	    ALU_SUB, 1'b0, 1'b1, BR_NONE}, 64'h8000_0000_0000_0000},
	// two min negatives, v c and z together
	'{'{64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000,
	    64'h301c, 64'h0, 64'hd,
	    ALU_ADD, 1'b0, 1'b1, BR_LT}, 64'h0}
};

`endif

//--- test/execute_stage_tb.sv
// execute_stage_tb
// drives the execute stage with a directed table and LCG rows,
// checks result, branch and flags against a reference model
`timescale 1ns/1ps
`default_nettype none

module execute_stage_tb import ex_pkg::*; ();

`include "ex_vectors.svh"

	localparam int RESET_CYCLES = 5;
	localparam int N_RAND       = 200;
	localparam int N_HOLD       = 8;
	// every row takes one cycle, plus reset and some slack
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_DIR + N_RAND + N_HOLD + 20;

	logic      clk;
	logic      reset;
	ex_req_t   req;
	ex_res_t   res;
	ex_flags_t flags;

	// reference copy of the flag register
	ex_flags_t   ref_flags;
	logic [63:0] lcg_state;
	int          checks;
	int          errors;
	int          test_checks;
	int          test_errors;
	int          cycle_count;

	execute_stage i_execute_stage (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.res   (res),
		.flags (flags)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// 64-bit LCG whose upper bits are the useful ones
	function automatic logic [63:0] lcg_next();
		lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcg_state;
	endfunction

	// ALU result straight from the op code rules
	function automatic logic [DATA_W-1:0] ref_alu(ex_req_t r);
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] y;
		a = r.read_data1;
		b = r.alu_src ? r.imm_ext : r.read_data2;
		case (r.alu_op)
			ALU_PASS_B: y = b;
			ALU_ADD:    y = a + b;
			ALU_SUB:    y = a - b;
			ALU_AND:    y = a & b;
			ALU_OR:     y = a | b;
			ALU_XOR:    y = a ^ b;
			default:    y = '0;
		endcase
		return y;
	endfunction

	// flags a set_flags row would load
	function automatic ex_flags_t next_flags(ex_req_t r, logic [DATA_W-1:0] y);
		ex_flags_t         f;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W:0]   wide;
		a = r.read_data1;
		b = r.alu_src ? r.imm_ext : r.read_data2;
		f.negative = y[DATA_W-1];
		f.zero     = (y == '0);
		f.overflow = 1'b0;
		f.carry    = 1'b0;
		if (r.alu_op == ALU_ADD) begin
			wide    = {1'b0, a} + {1'b0, b};
			f.carry = wide[DATA_W];
			// same-sign operands giving a sum with the other sign
			f.overflow = (a[DATA_W-1] == b[DATA_W-1]) && (y[DATA_W-1] != a[DATA_W-1]);
		end else if (r.alu_op == ALU_SUB) begin
			// carry means no borrow
			f.carry    = (a >= b);
			f.overflow = (a[DATA_W-1] != b[DATA_W-1]) && (y[DATA_W-1] != a[DATA_W-1]);
		end
		return f;
	endfunction

	// taken decision from the stored flags
	function automatic logic branch_decision(ex_req_t r, ex_flags_t f);
		logic t;
		case (r.br_kind)
			BR_ALWAYS: t = 1'b1;
			BR_CBZ:    t = (r.read_data2 == '0);
			BR_LT:     t = (f.negative != f.overflow);
			default:   t = 1'b0;
		endcase
		return t;
	endfunction

	function automatic ex_req_t random_row();
		ex_req_t     r;
		logic [63:0] ctl;
		r.read_data1 = lcg_next();
		r.read_data2 = lcg_next();
		r.pc         = lcg_next();
		r.imm_ext    = lcg_next();
		r.br_offset  = lcg_next();
		ctl          = lcg_next();
		r.alu_op     = ctl[34:32];
		r.alu_src    = ctl[40];
		r.set_flags  = ctl[44];
		r.br_kind    = ctl[49:48];
		// now and then a zero register for cbz
		if (ctl[55:52] == 4'h0)
			r.read_data2 = '0;
		// and equal operands for a zero result
		if (ctl[59:56] == 4'h0)
			r.read_data1 = r.alu_src ? r.imm_ext : r.read_data2;
		return r;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		test_checks++;
		if (got !== exp) begin
			test_errors++;
			$display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic start_test();
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		checks += test_checks;
		errors += test_errors;
	endtask

	// one request per cycle with outputs sampled at the falling edge
	task automatic apply_row(input ex_req_t r, input logic use_exp,
		input logic [DATA_W-1:0] exp_result);
		logic [DATA_W-1:0] y;
		logic [DATA_W-1:0] target;
		@(posedge clk);
		req <= r;
		@(negedge clk);
		y      = ref_alu(r);
		target = r.pc + r.br_offset * 64'd4;
		check_value("alu_result", res.alu_result, y);
		if (use_exp)
			check_value("alu_result (table)", res.alu_result, exp_result);
		check_value("store_data", res.store_data, r.read_data2);
		check_value("branch_target", res.branch_target, target);
		check_value("branch_taken", {63'b0, res.branch_taken},
			{63'b0, branch_decision(r, ref_flags)});
		// flags still show what earlier rows loaded
		check_value("flags", {60'b0, flags}, {60'b0, ref_flags});
		if (r.set_flags)
			ref_flags = next_flags(r, y);
	endtask

	initial begin
		ex_req_t   r;
		ex_flags_t held;
		checks    = 0;
		errors    = 0;
		reset     = 1'b1;
		req       = '0;
		ref_flags = '0;
		lcg_state = 64'd61;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		start_test();
		@(negedge clk);
		check_value("flags", {60'b0, flags}, 64'h0);
		finish_test("reset flags");

		start_test();
		for (int i = 0; i < N_DIR; i++)
			apply_row(DIRECTED[i].req, 1'b1, DIRECTED[i].exp_result);
		finish_test("directed table");

		start_test();
		for (int i = 0; i < N_RAND; i++)
			apply_row(random_row(), 1'b0, '0);
		finish_test("random rows");

		// load n from a compare, then rows that must not touch it
		start_test();
		apply_row(DIRECTED[12].req, 1'b1, DIRECTED[12].exp_result);
		held = ref_flags;
		for (int i = 0; i < N_HOLD; i++) begin
			r           = random_row();
			r.set_flags = 1'b0;
			apply_row(r, 1'b0, '0);
		end
		// flags after the edge that ends the last row
		@(negedge clk);
		check_value("flags held", {60'b0, flags}, {60'b0, held});
		finish_test("flag hold");

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// run limit
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
// execute_stage
// execute stage of the load/store core: operand select, a ripple
// chain of ALU bit slices, the flag register and the branch unit
`timescale 1ns/1ps
`default_nettype none

module execute_stage import ex_pkg::*; (
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire ex_req_t   req,
	output ex_res_t        res,
	output ex_flags_t      flags
);

	logic [DATA_W-1:0] b_vec;
	logic [DATA_W:0]   carry;
	logic [DATA_W-1:0] sum_bits;
	slice_ctl_t        slice_ctl;
	logic              arith;
	logic [DATA_W-1:0] alu_result;
	logic [DATA_W-1:0] branch_target;
	logic              branch_taken;

	// B operand, carry-in and slice controls
	operand_select i_operand_select (
		.req_op     (req.alu_op),
		.alu_src    (req.alu_src),
		.read_data2 (req.read_data2),
		.imm_ext    (req.imm_ext),
		.b_vec      (b_vec),
		.carry_in   (carry[0]),
		.slice_ctl  (slice_ctl),
		.arith      (arith)
	);

	// ripple chain, slice i carries into slice i+1
	for (genvar i = 0; i < DATA_W; i++) begin : g_slice
		alu_bit i_alu_bit (
			.a      (req.read_data1[i]),
			.b      (b_vec[i]),
			.cin    (carry[i]),
			.ctl    (slice_ctl),
			.result (sum_bits[i]),
			.cout   (carry[i+1])
		);
	end

	// result word and flag register
	// top slice carries feed overflow and carry
	alu_flags i_alu_flags (
		.clk           (clk),
		.reset         (reset),
		.sum_bits      (sum_bits),
		.carry_msb_in  (carry[DATA_W-1]),
		.carry_msb_out (carry[DATA_W]),
		.arith         (arith),
		.set_flags     (req.set_flags),
		.alu_result    (alu_result),
		.flags         (flags)
	);

	// target and taken, BR_LT reads the registered flags
	branch_unit i_branch_unit (
		.pc            (req.pc),
		.br_offset     (req.br_offset),
		.read_data2    (req.read_data2),
		.br_kind       (req.br_kind),
		.flags         (flags),
		.branch_target (branch_target),
		.branch_taken  (branch_taken)
	);

	// store data is read_data2 unchanged
	assign res = '{
		alu_result:    alu_result,
		store_data:    req.read_data2,
		branch_target: branch_target,
		branch_taken:  branch_taken
	};

endmodule

`default_nettype wire

//--- hdl/branch_unit.sv
// branch_unit
// branch target from pc plus the scaled word offset, and the
// taken decision for unconditional, cbz and less-than branches
`timescale 1ns/1ps
`default_nettype none

module branch_unit import ex_pkg::*; (
	input  wire logic [DATA_W-1:0] pc,
	input  wire logic [DATA_W-1:0] br_offset,
	input  wire logic [DATA_W-1:0] read_data2,
	input  wire logic [1:0]        br_kind,
	input  wire ex_flags_t         flags,
	output logic      [DATA_W-1:0] branch_target,
	output logic                   branch_taken
);

	logic [DATA_W-1:0] byte_offset;
	logic              rd2_zero;
	logic              less_than;

	// word offset to byte offset
	assign byte_offset   = br_offset << BR_SHIFT;
	assign branch_target = pc + byte_offset;

	// cbz looks at the register itself, not the flags
	assign rd2_zero = ~|read_data2;

	// signed less-than from the stored flags, n != v
	// stored flags, so a compare in the previous cycle steers this one
	assign less_than = flags.negative ^ flags.overflow;

	always_comb begin
		case (br_kind)
			BR_ALWAYS: branch_taken = 1'b1;
			BR_CBZ:    branch_taken = rd2_zero;
			BR_LT:     branch_taken = less_than;
			default:   branch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/alu_flags.sv
// alu_flags
// gathers the slice outputs into the result word and keeps the
// negative, zero, overflow and carry flags, loaded on set_flags
`timescale 1ns/1ps
`default_nettype none

module alu_flags import ex_pkg::*; (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic [DATA_W-1:0] sum_bits,
	input  wire logic              carry_msb_in,
	input  wire logic              carry_msb_out,
	input  wire logic              arith,
	input  wire logic              set_flags,
	output logic      [DATA_W-1:0] alu_result,
	output ex_flags_t              flags
);

	ex_flags_t flags_next;

	// result word straight from the slices
	assign alu_result = sum_bits;

	always_comb begin
		// sign and zero come from the result for every op
		flags_next.negative = sum_bits[DATA_W-1];
		flags_next.zero     = ~|sum_bits;
		// adder flags only mean something for add and sub
		if (arith) begin
			// signed overflow when carry into msb differs from carry out
			flags_next.overflow = carry_msb_in ^ carry_msb_out;
			flags_next.carry    = carry_msb_out;
		end else begin
			flags_next.overflow = 1'b0;
			flags_next.carry    = 1'b0;
		end
	end

	// flag register, held unless the instruction sets flags
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (set_flags) begin
			flags <= flags_next;
		end
	end

endmodule

`default_nettype wire

//--- hdl/alu_bit.sv
// alu_bit
// one ALU bit slice, a full adder with and/or/xor beside it,
// output chosen by the shared slice controls
`timescale 1ns/1ps
`default_nettype none

module alu_bit import ex_pkg::*; (
	input  wire logic       a,
	input  wire logic       b,
	input  wire logic       cin,
	input  wire slice_ctl_t ctl,
	output logic            result,
	output logic            cout
);

	logic half;
	logic sum;

	// full adder
	assign half = a ^ b;
	assign sum  = half ^ cin;
	assign cout = (a & b) | (cin & half);

	always_comb begin
		if (ctl.pass_b) begin
			// b arrives uninverted for pass
			result = b;
		end else begin
			case (ctl.logic_sel)
				LSEL_AND: result = a & b;
				LSEL_OR:  result = a | b;
				LSEL_XOR: result = half;
				default:  result = sum;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/operand_select.sv
// operand_select
// picks the B operand, inverts it for subtract and decodes the
// ALU op into carry-in and slice controls for the bit-slice chain
`timescale 1ns/1ps
`default_nettype none

module operand_select import ex_pkg::*; (
	input  wire logic [2:0]        req_op,
	input  wire logic              alu_src,
	input  wire logic [DATA_W-1:0] read_data2,
	input  wire logic [DATA_W-1:0] imm_ext,
	output logic      [DATA_W-1:0] b_vec,
	output logic                   carry_in,
	output slice_ctl_t             slice_ctl,
	output logic                   arith
);

	logic [DATA_W-1:0] b_sel;

	// immediate or register operand
	assign b_sel = alu_src ? imm_ext : read_data2;

	always_comb begin
		// defaults cover add and the logic ops
		b_vec               = b_sel;
		carry_in            = 1'b0;
		slice_ctl.pass_b    = 1'b0;
		slice_ctl.logic_sel = LSEL_SUM;
		arith               = 1'b0;
		case (req_op)
			ALU_PASS_B: slice_ctl.pass_b = 1'b1;
			ALU_ADD:    arith = 1'b1;
			ALU_SUB: begin
				// two's complement, a + ~b + 1
				b_vec    = ~b_sel;
				carry_in = 1'b1;
				arith    = 1'b1;
			end
			ALU_AND:    slice_ctl.logic_sel = LSEL_AND;
			ALU_OR:     slice_ctl.logic_sel = LSEL_OR;
			ALU_XOR:    slice_ctl.logic_sel = LSEL_XOR;
			default: begin
				// unused codes give zero, a & 0 in every slice
				b_vec               = '0;
				slice_ctl.logic_sel = LSEL_AND;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/ex_pkg.sv
// ex_pkg
// shared widths, ALU op codes, branch kinds and the structs used
// across the execute stage of the 64-bit load/store core
`default_nettype none

package ex_pkg;

	// datapath width and word-to-byte shift for branch offsets
	localparam int DATA_W   = 64;
	localparam int BR_SHIFT = 2;

	// ALU operation codes, as driven by decode
	localparam logic [2:0] ALU_PASS_B = 3'b000;
	localparam logic [2:0] ALU_ADD    = 3'b010;
	localparam logic [2:0] ALU_SUB    = 3'b011;
	localparam logic [2:0] ALU_AND    = 3'b100;
	localparam logic [2:0] ALU_OR     = 3'b101;
	localparam logic [2:0] ALU_XOR    = 3'b110;

	// branch kinds
	localparam logic [1:0] BR_NONE   = 2'b00;
	localparam logic [1:0] BR_ALWAYS = 2'b01;
	localparam logic [1:0] BR_CBZ    = 2'b10;
	localparam logic [1:0] BR_LT     = 2'b11;

	// slice output select, one per bit slice
	localparam logic [1:0] LSEL_AND = 2'b00;
	localparam logic [1:0] LSEL_OR  = 2'b01;
	localparam logic [1:0] LSEL_XOR = 2'b10;
	localparam logic [1:0] LSEL_SUM = 2'b11;

	// request from decode, already extended and read
	typedef struct packed {
		logic [DATA_W-1:0] read_data1;
		logic [DATA_W-1:0] read_data2;
		logic [DATA_W-1:0] pc;
		logic [DATA_W-1:0] imm_ext;
		logic [DATA_W-1:0] br_offset;
		logic [2:0]        alu_op;
		logic              alu_src;   // set picks imm_ext as B
		logic              set_flags;
		logic [1:0]        br_kind;
	} ex_req_t;

	// results handed on to memory access and fetch
	typedef struct packed {
		logic [DATA_W-1:0] alu_result;
		logic [DATA_W-1:0] store_data;
		logic [DATA_W-1:0] branch_target;
		logic              branch_taken;
	} ex_res_t;

	// condition flags
	typedef struct packed {
		logic negative;
		logic zero;
		logic overflow;
		logic carry;
	} ex_flags_t;

	// per-slice controls, decoded once for the whole chain
	typedef struct packed {
		logic [1:0] logic_sel;
		logic       pass_b;
	} slice_ctl_t;

endpackage

`default_nettype wire
